// ==== alu_exec_unit.f ====
+incdir+include
src/alu_pkg.sv
src/issue_bus_if.sv
src/exec_bus_if.sv
src/operand_decode.sv
src/issue_latch.sv
src/alu_execute.sv
src/reg_file.sv
src/alu_exec_unit.sv
tests/tb_clock_gen.sv
tests/tb_alu_exec_unit.sv

// ==== tests/tb_alu_exec_unit.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

module tb_alu_exec_unit;

    localparam int CLK_PERIOD = 100;
    localparam int N_RANDOM   = 64;
    localparam int N_DEP      = 64;
    localparam int DRAIN      = 4;
    localparam int PRELOAD    = 2 * 31;
    localparam int RUN_CYCLES = 10 + 3 * (PRELOAD + N_RANDOM + DRAIN) + 42
                              + 2 * N_DEP + DRAIN + 20 + DRAIN;
    localparam longint WATCHDOG_NS = longint'(RUN_CYCLES + 100) * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic              instr_valid;
    alu_pkg::bus32_t   instr;
    alu_pkg::bus32_t   instr_pc;
    logic              result_valid;
    alu_pkg::reg_idx_t result_rd;
    alu_pkg::bus32_t   result_data;

    // Reference state: register file plus the instruction just ahead, reached only by forwarding
    alu_pkg::bus32_t   model_regs [32];
    logic              p1_wen;
    alu_pkg::reg_idx_t p1_rd;
    alu_pkg::bus32_t   p1_data;

    alu_pkg::reg_idx_t exp_rd_q [$];
    alu_pkg::bus32_t   exp_data_q [$];
    time               exp_time_q [$];
    alu_pkg::reg_idx_t want_rd;
    alu_pkg::bus32_t   want_data;
    time               want_time;

    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    err_at_start;
    string cur_name;

    alu_pkg::alu_op_t logic_shift_ops [14] = '{
        alu_pkg::ALU_OR, alu_pkg::ALU_ORI, alu_pkg::ALU_LU12I, alu_pkg::ALU_NOR,
        alu_pkg::ALU_AND, alu_pkg::ALU_ANDI, alu_pkg::ALU_XOR, alu_pkg::ALU_XORI,
        alu_pkg::ALU_SLLW, alu_pkg::ALU_SLLIW, alu_pkg::ALU_SRLW, alu_pkg::ALU_SRLIW,
        alu_pkg::ALU_SRAW, alu_pkg::ALU_SRAIW
    };
    alu_pkg::alu_op_t arith_ops [8] = '{
        alu_pkg::ALU_ADDW, alu_pkg::ALU_SUBW, alu_pkg::ALU_ADDIW, alu_pkg::ALU_PCADDU12I,
        alu_pkg::ALU_SLT, alu_pkg::ALU_SLTU, alu_pkg::ALU_SLTI, alu_pkg::ALU_SLTUI
    };
    alu_pkg::alu_op_t mul_ops [3] = '{
        alu_pkg::ALU_MULW, alu_pkg::ALU_MULHW, alu_pkg::ALU_MULHWU
    };
    alu_pkg::alu_op_t dep_ops [8] = '{
        alu_pkg::ALU_ADDW, alu_pkg::ALU_SUBW, alu_pkg::ALU_XOR, alu_pkg::ALU_OR,
        alu_pkg::ALU_SLLW, alu_pkg::ALU_ADDIW, alu_pkg::ALU_MULW, alu_pkg::ALU_SRAW
    };
    alu_pkg::bus32_t edge_vals [6] = '{
        32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
        32'h8000_0000, 32'hffff_ffff, 32'h8000_0001
    };
    logic [5:0] bad_ops [4] = '{6'h00, 6'h09, 6'h1f, 6'h3f};

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) i_clock_gen (.clk(clk));

    alu_exec_unit i_alu_exec_unit (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    function automatic alu_pkg::bus32_t encode_reg(input logic [5:0] op,
            input alu_pkg::reg_idx_t rd, input alu_pkg::reg_idx_t rj, input logic [15:0] low);
        return {op, rd, rj, low};
    endfunction

    function automatic alu_pkg::bus32_t encode_u20(input logic [5:0] op,
            input alu_pkg::reg_idx_t rd, input logic [19:0] imm);
        return {op, rd, 1'b0, imm};
    endfunction

    // Returns whether the opcode is legal; res is the value the instruction produces
    function automatic bit model_exec(input alu_pkg::bus32_t word, input alu_pkg::bus32_t pc,
            input alu_pkg::bus32_t vj, input alu_pkg::bus32_t vk, output alu_pkg::bus32_t res);
        alu_pkg::bus32_t zimm;
        alu_pkg::bus32_t simm;
        alu_pkg::bus32_t upper;
        longint          prod;
        logic [63:0]     uprod;
        bit              legal;
        zimm  = {20'b0, word[`IMM12_RANGE]};
        simm  = {{20{word[11]}}, word[`IMM12_RANGE]};
        upper = {word[`IMM20_RANGE], 12'b0};
        prod  = longint'($signed(vj)) * longint'($signed(vk));
        uprod = {32'b0, vj} * {32'b0, vk};
        legal = 1'b1;
        res   = '0;
        case (word[`OPCODE_RANGE])
            alu_pkg::ALU_OR:        res = vj | vk;
            alu_pkg::ALU_ORI:       res = vj | zimm;
            alu_pkg::ALU_LU12I:     res = upper;
            alu_pkg::ALU_NOR:       res = ~(vj | vk);
            alu_pkg::ALU_AND:       res = vj & vk;
            alu_pkg::ALU_ANDI:      res = vj & zimm;
            alu_pkg::ALU_XOR:       res = vj ^ vk;
            alu_pkg::ALU_XORI:      res = vj ^ zimm;
            alu_pkg::ALU_SLLW:      res = vj << vk[4:0];
            alu_pkg::ALU_SLLIW:     res = vj << word[`IMM5_RANGE];
            alu_pkg::ALU_SRLW:      res = vj >> vk[4:0];
            alu_pkg::ALU_SRLIW:     res = vj >> word[`IMM5_RANGE];
            alu_pkg::ALU_SRAW:      res = $signed(vj) >>> vk[4:0];
            alu_pkg::ALU_SRAIW:     res = $signed(vj) >>> word[`IMM5_RANGE];
            alu_pkg::ALU_ADDW:      res = vj + vk;
            alu_pkg::ALU_SUBW:      res = vj - vk;
            alu_pkg::ALU_ADDIW:     res = vj + simm;
            alu_pkg::ALU_PCADDU12I: res = pc + upper;
            alu_pkg::ALU_SLT:       res = ($signed(vj) < $signed(vk)) ? 32'd1 : 32'd0;
            alu_pkg::ALU_SLTU:      res = (vj < vk) ? 32'd1 : 32'd0;
            alu_pkg::ALU_SLTI:      res = ($signed(vj) < $signed(simm)) ? 32'd1 : 32'd0;
            alu_pkg::ALU_SLTUI:     res = (vj < simm) ? 32'd1 : 32'd0;
            alu_pkg::ALU_MULW:      res = prod[31:0];
            alu_pkg::ALU_MULHW:     res = prod[63:32];
            alu_pkg::ALU_MULHWU:    res = uprod[63:32];
            default:                legal = 1'b0;
        endcase
        return legal;
    endfunction

    // One clock: drive the next slot and advance the reference by one cycle
    task automatic step(input bit valid, input alu_pkg::bus32_t word,
            input alu_pkg::bus32_t pc);
        alu_pkg::reg_idx_t rd;
        alu_pkg::reg_idx_t rj;
        alu_pkg::reg_idx_t rk;
        alu_pkg::bus32_t   vj;
        alu_pkg::bus32_t   vk;
        alu_pkg::bus32_t   res;
        bit                legal;
        @(posedge clk);
        instr_valid <= valid;
        instr       <= word;
        instr_pc    <= pc;
        rd = word[`RD_RANGE];
        rj = word[`RJ_RANGE];
        rk = word[`RK_RANGE];
        vj = (p1_wen && p1_rd == rj) ? p1_data : model_regs[rj];
        vk = (p1_wen && p1_rd == rk) ? p1_data : model_regs[rk];
        legal = model_exec(word, pc, vj, vk, res);
        // The instruction just ahead is in the register file by the time the next one reads
        if (p1_wen) begin
            model_regs[p1_rd] = p1_data;
        end
        p1_wen  = valid && legal && (rd != 0);
        p1_rd   = rd;
        p1_data = res;
        if (valid) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
            exp_time_q.push_back($time + 3 * CLK_PERIOD);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0, '0);
    endtask

    task automatic load_reg(input alu_pkg::reg_idx_t r, input alu_pkg::bus32_t value);
        logic [19:0] hi;
        // ADDIW sign-extends its immediate, so the upper part absorbs the carry
        hi = value[31:12] + value[11];
        step(1'b1, encode_u20(alu_pkg::ALU_LU12I, r, hi), '0);
        step(1'b1, encode_reg(alu_pkg::ALU_ADDIW, r, r, {4'b0, value[11:0]}), '0);
    endtask

    task automatic preload_regs(input bit with_edges);
        alu_pkg::bus32_t v;
        for (int r = 1; r < 32; r++) begin
            v = $urandom;
            if (with_edges && r <= 6) begin
                v = edge_vals[r-1];
            end
            load_reg(alu_pkg::reg_idx_t'(r), v);
        end
    endtask

    task automatic random_instrs(input int kind, input int count);
        alu_pkg::alu_op_t op;
        alu_pkg::bus32_t  w;
        repeat (count) begin
            case (kind)
                0:       op = logic_shift_ops[$urandom_range(13, 0)];
                1:       op = arith_ops[$urandom_range(7, 0)];
                default: op = mul_ops[$urandom_range(2, 0)];
            endcase
            w = $urandom;
            w[`OPCODE_RANGE] = op;
            w[`RD_RANGE]     = alu_pkg::reg_idx_t'($urandom_range(31, 7));
            step(1'b1, w, $urandom & 32'hffff_fffc);
        end
    endtask

    // Registers 1 to 6 hold the boundary values after a preload with edges
    task automatic edge_pairs(input alu_pkg::alu_op_t op);
        for (int j = 1; j <= 6; j++) begin
            step(1'b1, encode_reg(op, alu_pkg::reg_idx_t'(6 + j), alu_pkg::reg_idx_t'(j),
                 {5'((j % 6) + 1), 11'd0}), '0);
        end
    endtask

    task automatic dependent_instrs(input int count);
        alu_pkg::alu_op_t op;
        logic [10:0]      low;
        repeat (count) begin
            op  = dep_ops[$urandom_range(7, 0)];
            low = $urandom_range(2047, 0);
            step(1'b1, encode_reg(op, alu_pkg::reg_idx_t'($urandom_range(6, 1)),
                 alu_pkg::reg_idx_t'($urandom_range(6, 1)),
                 {5'($urandom_range(6, 1)), low}), '0);
            if ($urandom_range(3, 0) == 0) begin
                idle(1);
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_name     = name;
        err_at_start = errors;
    endtask

    task automatic finish_test();
        idle(DRAIN);
        assert (exp_rd_q.size() == 0) else begin
            $display("%0d expected results never appeared in test %s",
                     exp_rd_q.size(), cur_name);
            errors++;
            exp_rd_q.delete();
            exp_data_q.delete();
            exp_time_q.delete();
        end
        tests_run++;
        if (errors == err_at_start) begin
            $display("Test %s: passed", cur_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", cur_name, errors - err_at_start);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && result_valid) begin
            assert (exp_rd_q.size() > 0) else begin
                $display("Result for rd %0d appeared with no instruction outstanding", result_rd);
                errors++;
            end
            if (exp_rd_q.size() > 0) begin
                want_rd   = exp_rd_q.pop_front();
                want_data = exp_data_q.pop_front();
                want_time = exp_time_q.pop_front();
                checks++;
                assert (result_rd == want_rd) else begin
                    $display("Fail result_rd: got %h, expected %h", result_rd, want_rd);
                    errors++;
                end
                assert (result_data == want_data) else begin
                    $display("Fail result_data: got %h, expected %h", result_data, want_data);
                    errors++;
                end
                assert ($time == want_time) else begin
                    $display("Result for rd %0d arrived at %0t instead of %0t",
                             want_rd, $time, want_time);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        p1_wen      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(61));

        start_test("reset");
        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            assert (result_valid === 1'b0) else begin
                $display("Fail result_valid: got %h, expected 0", result_valid);
                errors++;
            end
            @(posedge clk);
        end
        rst <= 1'b0;
        finish_test();

        start_test("logic and shift");
        preload_regs(1'b0);
        random_instrs(0, N_RANDOM);
        finish_test();

        start_test("arithmetic and compare");
        preload_regs(1'b1);
        edge_pairs(alu_pkg::ALU_SLT);
        edge_pairs(alu_pkg::ALU_SLTU);
        edge_pairs(alu_pkg::ALU_ADDW);
        edge_pairs(alu_pkg::ALU_SUBW);
        random_instrs(1, N_RANDOM);
        finish_test();

        start_test("multiply");
        preload_regs(1'b1);
        edge_pairs(alu_pkg::ALU_MULW);
        edge_pairs(alu_pkg::ALU_MULHW);
        edge_pairs(alu_pkg::ALU_MULHWU);
        random_instrs(2, N_RANDOM);
        finish_test();

        start_test("dependent instructions");
        dependent_instrs(N_DEP);
        finish_test();

        start_test("r0 and illegal opcodes");
        step(1'b1, encode_reg(alu_pkg::ALU_ADDIW, 5'd0, 5'd1, 16'h0123), '0);
        step(1'b1, encode_u20(alu_pkg::ALU_LU12I, 5'd0, 20'habcde), '0);
        step(1'b1, encode_reg(alu_pkg::ALU_OR, 5'd8, 5'd0, 16'h0000), '0);
        idle(2);
        step(1'b1, encode_reg(alu_pkg::ALU_ADDW, 5'd9, 5'd0, 16'h0000), '0);
        for (int i = 0; i < 4; i++) begin
            step(1'b1, encode_reg(bad_ops[i], 5'd10, 5'($urandom), 16'($urandom)), '0);
            step(1'b1, encode_reg(alu_pkg::ALU_OR, 5'd11, 5'd10, 16'h0000), '0);
        end
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== src/alu_exec_unit.sv ====
`timescale 1ns/1ps

module alu_exec_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  alu_pkg::bus32_t   instr,
    input  alu_pkg::bus32_t   instr_pc,
    output logic              result_valid,
    output alu_pkg::reg_idx_t result_rd,
    output alu_pkg::bus32_t   result_data
);

    alu_pkg::reg_idx_t rj_addr;
    alu_pkg::reg_idx_t rk_addr;
    alu_pkg::bus32_t   rj_data;
    alu_pkg::bus32_t   rk_data;
    alu_pkg::bus32_t   fwd_data;
    logic              wb_en;
    alu_pkg::reg_idx_t wb_addr;
    alu_pkg::bus32_t   wb_data;

    issue_bus_if i_issue_bus ();
    exec_bus_if  i_exec_bus ();

    operand_decode i_operand_decode (
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .rj_addr     (rj_addr),
        .rk_addr     (rk_addr),
        .rj_data     (rj_data),
        .rk_data     (rk_data),
        .issue       (i_issue_bus.producer)
    );

    issue_latch i_issue_latch (
        .clk      (clk),
        .rst      (rst),
        .fwd_data (fwd_data),
        .issue    (i_issue_bus.buffer),
        .exec     (i_exec_bus.buffer)
    );

    alu_execute i_alu_execute (
        .clk          (clk),
        .rst          (rst),
        .exec         (i_exec_bus.execute),
        .fwd_data     (fwd_data),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rj_addr (rj_addr),
        .rk_addr (rk_addr),
        .rj_data (rj_data),
        .rk_data (rk_data),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  alu_pkg::reg_idx_t rj_addr,
    input  alu_pkg::reg_idx_t rk_addr,
    output alu_pkg::bus32_t   rj_data,
    output alu_pkg::bus32_t   rk_data,
    input  logic              wb_en,
    input  alu_pkg::reg_idx_t wb_addr,
    input  alu_pkg::bus32_t   wb_data
);

    alu_pkg::bus32_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Reads see the old value during the write cycle
    assign rj_data = regs[rj_addr];
    assign rk_data = regs[rk_addr];

endmodule

// ==== src/alu_execute.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_execute (
    input  logic              clk,
    input  logic              rst,
    exec_bus_if.execute       exec,
    output alu_pkg::bus32_t   fwd_data,
    output logic              wb_en,
    output alu_pkg::reg_idx_t wb_addr,
    output alu_pkg::bus32_t   wb_data,
    output logic              result_valid,
    output alu_pkg::reg_idx_t result_rd,
    output alu_pkg::bus32_t   result_data
);

    alu_pkg::bus32_t src1;
    alu_pkg::bus32_t src2;
    alu_pkg::bus32_t logic_res;
    alu_pkg::bus32_t shift_res;
    alu_pkg::bus32_t arith_res;
    alu_pkg::bus32_t result;
    alu_pkg::bus64_t mul_signed;
    alu_pkg::bus64_t mul_unsigned;
    logic            less_than;

    assign src1 = exec.reg1;
    assign src2 = exec.reg2;

    always_comb begin
        case (exec.op)
            alu_pkg::ALU_OR, alu_pkg::ALU_ORI, alu_pkg::ALU_LU12I: logic_res = src1 | src2;
            alu_pkg::ALU_NOR:                                      logic_res = ~(src1 | src2);
            alu_pkg::ALU_AND, alu_pkg::ALU_ANDI:                   logic_res = src1 & src2;
            alu_pkg::ALU_XOR, alu_pkg::ALU_XORI:                   logic_res = src1 ^ src2;
            default:                                               logic_res = '0;
        endcase
    end

    // Only the low five bits of the second operand count as shift amount
    always_comb begin
        case (exec.op)
            alu_pkg::ALU_SLLW, alu_pkg::ALU_SLLIW: shift_res = src1 << src2[4:0];
            alu_pkg::ALU_SRLW, alu_pkg::ALU_SRLIW: shift_res = src1 >> src2[4:0];
            alu_pkg::ALU_SRAW, alu_pkg::ALU_SRAIW: shift_res = $signed(src1) >>> src2[4:0];
            default:                               shift_res = '0;
        endcase
    end

    always_comb begin
        if (exec.op == alu_pkg::ALU_SLT || exec.op == alu_pkg::ALU_SLTI) begin
            less_than = $signed(src1) < $signed(src2);
        end else begin
            less_than = src1 < src2;
        end
    end

    // Both products are 64 bits wide, the signed one extends its operands first
    assign mul_signed   = $signed(src1) * $signed(src2);
    assign mul_unsigned = {{`XLEN{1'b0}}, src1} * {{`XLEN{1'b0}}, src2};

    always_comb begin
        case (exec.op)
            alu_pkg::ALU_ADDW, alu_pkg::ALU_ADDIW, alu_pkg::ALU_PCADDU12I: begin
                arith_res = src1 + src2;
            end
            alu_pkg::ALU_SUBW: begin
                arith_res = src1 - src2;
            end
            alu_pkg::ALU_SLT, alu_pkg::ALU_SLTU, alu_pkg::ALU_SLTI, alu_pkg::ALU_SLTUI: begin
                arith_res = alu_pkg::bus32_t'(less_than);
            end
            alu_pkg::ALU_MULW: begin
                arith_res = mul_signed[`XLEN-1:0];
            end
            alu_pkg::ALU_MULHW: begin
                arith_res = mul_signed[2*`XLEN-1:`XLEN];
            end
            alu_pkg::ALU_MULHWU: begin
                arith_res = mul_unsigned[2*`XLEN-1:`XLEN];
            end
            default: begin
                arith_res = '0;
            end
        endcase
    end

    always_comb begin
        case (exec.sel)
            alu_pkg::ALU_SEL_LOGIC: result = logic_res;
            alu_pkg::ALU_SEL_SHIFT: result = shift_res;
            alu_pkg::ALU_SEL_ARITH: result = arith_res;
            default:                result = '0;
        endcase
    end

    assign fwd_data = result;

    // The register file stores the result at the same edge that loads the result ports
    assign wb_en   = exec.valid && exec.wen;
    assign wb_addr = exec.rd;
    assign wb_data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= exec.valid;
        end
    end

    always_ff @(posedge clk) begin
        result_rd   <= exec.rd;
        result_data <= result;
    end

endmodule

// ==== src/issue_latch.sv ====
`timescale 1ns/1ps

module issue_latch (
    input  logic            clk,
    input  logic            rst,
    input  alu_pkg::bus32_t fwd_data,
    issue_bus_if.buffer     issue,
    exec_bus_if.buffer      exec
);

    logic held_writes;
    logic fwd_rj;
    logic fwd_rk;

    // The instruction now in execute has not reached the register file yet
    assign held_writes = exec.valid && exec.wen;
    assign fwd_rj      = held_writes && issue.use_rj && (exec.rd == issue.rj);
    assign fwd_rk      = held_writes && issue.use_rk && (exec.rd == issue.rk);

    always_ff @(posedge clk) begin
        if (rst) begin
            exec.valid <= 1'b0;
            exec.wen   <= 1'b0;
        end else begin
            exec.valid <= issue.valid;
            exec.wen   <= issue.valid && issue.wen;
        end
    end

    always_ff @(posedge clk) begin
        exec.op   <= issue.op;
        exec.sel  <= issue.sel;
        exec.rd   <= issue.rd;
        exec.reg1 <= fwd_rj ? fwd_data : issue.reg1;
        exec.reg2 <= fwd_rk ? fwd_data : issue.reg2;
    end

endmodule

// ==== src/operand_decode.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

module operand_decode (
    input  alu_pkg::bus32_t   instr,
    input  alu_pkg::bus32_t   instr_pc,
    input  logic              instr_valid,
    output alu_pkg::reg_idx_t rj_addr,
    output alu_pkg::reg_idx_t rk_addr,
    input  alu_pkg::bus32_t   rj_data,
    input  alu_pkg::bus32_t   rk_data,
    issue_bus_if.producer     issue
);

    alu_pkg::alu_op_t  op;
    alu_pkg::reg_idx_t rd;
    logic [11:0]       imm12;
    alu_pkg::bus32_t   ui12;
    alu_pkg::bus32_t   si12;
    alu_pkg::bus32_t   ui5;
    alu_pkg::bus32_t   si20_hi;
    logic              legal;

    // Unknown codes pass through the cast and fall into the default arm
    assign op      = alu_pkg::alu_op_t'(instr[`OPCODE_RANGE]);
    assign rd      = instr[`RD_RANGE];
    assign rj_addr = instr[`RJ_RANGE];
    assign rk_addr = instr[`RK_RANGE];

    assign imm12   = instr[`IMM12_RANGE];
    assign ui12    = {{(`XLEN-12){1'b0}}, imm12};
    assign si12    = {{(`XLEN-12){imm12[11]}}, imm12};
    assign ui5     = {{(`XLEN-5){1'b0}}, instr[`IMM5_RANGE]};
    assign si20_hi = {instr[`IMM20_RANGE], 12'b0};

    always_comb begin
        issue.sel    = alu_pkg::ALU_SEL_NONE;
        issue.reg1   = rj_data;
        issue.reg2   = rk_data;
        issue.use_rj = 1'b0;
        issue.use_rk = 1'b0;
        legal        = 1'b1;
        case (op)
            alu_pkg::ALU_OR, alu_pkg::ALU_NOR, alu_pkg::ALU_AND, alu_pkg::ALU_XOR: begin
                issue.sel    = alu_pkg::ALU_SEL_LOGIC;
                issue.use_rj = 1'b1;
                issue.use_rk = 1'b1;
            end
            alu_pkg::ALU_ORI, alu_pkg::ALU_ANDI, alu_pkg::ALU_XORI: begin
                issue.sel    = alu_pkg::ALU_SEL_LOGIC;
                issue.reg2   = ui12;
                issue.use_rj = 1'b1;
            end
            alu_pkg::ALU_LU12I: begin
                // OR with zero places the upper immediate as is
                issue.sel  = alu_pkg::ALU_SEL_LOGIC;
                issue.reg1 = '0;
                issue.reg2 = si20_hi;
            end
            alu_pkg::ALU_SLLW, alu_pkg::ALU_SRLW, alu_pkg::ALU_SRAW: begin
                issue.sel    = alu_pkg::ALU_SEL_SHIFT;
                issue.use_rj = 1'b1;
                issue.use_rk = 1'b1;
            end
            alu_pkg::ALU_SLLIW, alu_pkg::ALU_SRLIW, alu_pkg::ALU_SRAIW: begin
                issue.sel    = alu_pkg::ALU_SEL_SHIFT;
                issue.reg2   = ui5;
                issue.use_rj = 1'b1;
            end
            alu_pkg::ALU_ADDW, alu_pkg::ALU_SUBW, alu_pkg::ALU_SLT, alu_pkg::ALU_SLTU,
            alu_pkg::ALU_MULW, alu_pkg::ALU_MULHW, alu_pkg::ALU_MULHWU: begin
                issue.sel    = alu_pkg::ALU_SEL_ARITH;
                issue.use_rj = 1'b1;
                issue.use_rk = 1'b1;
            end
            alu_pkg::ALU_ADDIW, alu_pkg::ALU_SLTI, alu_pkg::ALU_SLTUI: begin
                issue.sel    = alu_pkg::ALU_SEL_ARITH;
                issue.reg2   = si12;
                issue.use_rj = 1'b1;
            end
            alu_pkg::ALU_PCADDU12I: begin
                issue.sel  = alu_pkg::ALU_SEL_ARITH;
                issue.reg1 = instr_pc;
                issue.reg2 = si20_hi;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign issue.valid = instr_valid;
    assign issue.op    = op;
    assign issue.rd    = rd;
    assign issue.rj    = rj_addr;
    assign issue.rk    = rk_addr;
    // r0 is never written, so it reads back as zero after reset
    assign issue.wen   = legal && (rd != '0);

endmodule

// ==== src/exec_bus_if.sv ====
`timescale 1ns/1ps

interface exec_bus_if;

    logic              valid;
    alu_pkg::alu_op_t  op;
    alu_pkg::alu_sel_t sel;
    alu_pkg::bus32_t   reg1;
    alu_pkg::bus32_t   reg2;
    alu_pkg::reg_idx_t rd;
    logic              wen;

    modport buffer (
        output valid, op, sel, reg1, reg2, rd, wen
    );

    modport execute (
        input valid, op, sel, reg1, reg2, rd, wen
    );

endinterface

// ==== src/issue_bus_if.sv ====
`timescale 1ns/1ps

interface issue_bus_if;

    logic              valid;
    alu_pkg::alu_op_t  op;
    alu_pkg::alu_sel_t sel;
    alu_pkg::bus32_t   reg1;
    alu_pkg::bus32_t   reg2;
    alu_pkg::reg_idx_t rd;
    logic              wen;
    alu_pkg::reg_idx_t rj;
    alu_pkg::reg_idx_t rk;
    logic              use_rj;
    logic              use_rk;

    modport producer (
        output valid, op, sel, reg1, reg2, rd, wen, rj, rk, use_rj, use_rk
    );

    modport buffer (
        input valid, op, sel, reg1, reg2, rd, wen, rj, rk, use_rj, use_rk
    );

endinterface

// ==== src/alu_pkg.sv ====
`include "alu_params.svh"

package alu_pkg;

    typedef logic [`XLEN-1:0]      bus32_t;
    typedef logic [2*`XLEN-1:0]    bus64_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // Opcode values are this slice's own encoding; 6'h00 and the gaps are illegal
    typedef enum logic [5:0] {
        ALU_OR        = 6'h01,
        ALU_ORI       = 6'h02,
        ALU_LU12I     = 6'h03,
        ALU_NOR       = 6'h04,
        ALU_AND       = 6'h05,
        ALU_ANDI      = 6'h06,
        ALU_XOR       = 6'h07,
        ALU_XORI      = 6'h08,
        ALU_SLLW      = 6'h10,
        ALU_SLLIW     = 6'h11,
        ALU_SRLW      = 6'h12,
        ALU_SRLIW     = 6'h13,
        ALU_SRAW      = 6'h14,
        ALU_SRAIW     = 6'h15,
        ALU_ADDW      = 6'h20,
        ALU_SUBW      = 6'h21,
        ALU_ADDIW     = 6'h22,
        ALU_PCADDU12I = 6'h23,
        ALU_SLT       = 6'h24,
        ALU_SLTU      = 6'h25,
        ALU_SLTI      = 6'h26,
        ALU_SLTUI     = 6'h27,
        ALU_MULW      = 6'h28,
        ALU_MULHW     = 6'h29,
        ALU_MULHWU    = 6'h2a
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_SEL_LOGIC = 2'd0,
        ALU_SEL_SHIFT = 2'd1,
        ALU_SEL_ARITH = 2'd2,
        ALU_SEL_NONE  = 2'd3
    } alu_sel_t;

endpackage

// ==== include/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define XLEN        32
`define NUM_REGS    32
`define REG_IDX_W   5

// Field ranges inside the instruction word
`define OPCODE_RANGE 31:26
`define RD_RANGE     25:21
`define RJ_RANGE     20:16
`define RK_RANGE     15:11
`define IMM12_RANGE  11:0
`define IMM5_RANGE   4:0
`define IMM20_RANGE  19:0

`endif
